//--- hw/mac_pkg.sv
////////////////////
// mac unit shared definitions
// operator and high-multiply state encodings, datapath widths
////////////////////

package mac_pkg;

  ////////////////////
  // widths
  ////////////////////

  // full word of the execute stage
  localparam int unsigned DATA_W  = 32;
  // half word, one short multiplier operand
  localparam int unsigned HALF_W  = 16;
  localparam int unsigned BYTE_W  = 8;
  // shift immediate of the short path
  localparam int unsigned SHAMT_W = 5;

  // re-alignment of partial products between high-multiply steps
  localparam logic [SHAMT_W-1:0] MULH_SHIFT = 5'd16;

  ////////////////////
  // encodings
  ////////////////////

  // multiplier operator, decoded in the ID stage
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101,
    MUL_H     = 3'b110
  } mac_op_e;

  // high multiply sequence, one partial product per state
  typedef enum logic [2:0] {
    IDLE_MULT,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } mulh_state_e;

endpackage

//--- hw/mac_req_if.sv
////////////////////
// mac request bundle
// one multiplier operation as issued by the execute stage
////////////////////

interface mac_req_if;

  logic                         enable;
  mac_pkg::mac_op_e             operator;
  logic [mac_pkg::DATA_W-1:0]   op_a;
  logic [mac_pkg::DATA_W-1:0]   op_b;
  logic [mac_pkg::DATA_W-1:0]   op_c;
  logic [mac_pkg::SHAMT_W-1:0]  imm;

  // short path controls, one subword bit for both operands
  logic                         short_subword;
  // bit 0 signs A, bit 1 signs B
  logic [1:0]                   short_signed;

  // dot product operands
  logic [1:0]                   dot_signed;
  logic [mac_pkg::DATA_W-1:0]   dot_op_a;
  logic [mac_pkg::DATA_W-1:0]   dot_op_b;
  logic [mac_pkg::DATA_W-1:0]   dot_op_c;

  modport src (
    output enable, operator, op_a, op_b, op_c, imm,
    output short_subword, short_signed,
    output dot_signed, dot_op_a, dot_op_b, dot_op_c
  );

  modport int_sink (
    input operator, op_a, op_b, op_c, imm, short_subword, short_signed
  );

  modport ctrl_sink (input enable, operator, short_signed);

endinterface

//--- hw/mulh_ctrl.sv
////////////////////
// high multiply sequencer
// walks a 32x32 mulh through four 16x16 partial products
////////////////////

module mulh_ctrl
  import mac_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  mac_req_if.ctrl_sink        req,
  input  logic                ex_ready_i,
  input  logic [1:0]          sum_hi_i,
  output logic                mulh_active_o,
  output logic [SHAMT_W-1:0]  step_imm_o,
  output logic [1:0]          step_subword_o,
  output logic [1:0]          step_signed_o,
  output logic                step_shift_arith_o,
  output logic                carry_o,
  output logic                multicycle_o,
  output logic                ready_o
);

  mulh_state_e state_q, state_d;
  logic        carry_q;
  logic        carry_save;
  logic        carry_clear;

  always_comb begin
    state_d            = state_q;
    mulh_active_o      = 1'b1;
    step_imm_o         = '0;
    step_subword_o     = 2'b00;
    step_signed_o      = 2'b00;
    step_shift_arith_o = 1'b0;
    carry_save         = 1'b0;
    carry_clear        = 1'b0;
    multicycle_o       = 1'b0;
    ready_o            = 1'b0;
    case (state_q)
      IDLE_MULT: begin
        mulh_active_o = 1'b0;
        ready_o       = 1'b1;
        // drop ready in the issue cycle already
        if (req.enable && (req.operator == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      STEP0: begin
        // AL*BL, always unsigned, keep only the upper half
        multicycle_o = 1'b1;
        step_imm_o   = MULH_SHIFT;
        state_d      = STEP1;
      end
      STEP1: begin
        // AL*BH, signed iff B is signed
        // 33 bit result, top bit goes to the carry and no shift
        multicycle_o       = 1'b1;
        step_signed_o      = {req.short_signed[1], 1'b0};
        step_subword_o     = 2'b10;
        step_shift_arith_o = 1'b1;
        carry_save         = 1'b1;
        state_d            = STEP2;
      end
      STEP2: begin
        // AH*BL, signed iff A is signed
        // bits 33:32 are shifted back down, so the carry is dropped
        multicycle_o       = 1'b1;
        step_signed_o      = {1'b0, req.short_signed[0]};
        step_subword_o     = 2'b01;
        step_imm_o         = MULH_SHIFT;
        step_shift_arith_o = 1'b1;
        carry_save         = 1'b1;
        carry_clear        = 1'b1;
        state_d            = FINISH;
      end
      FINISH: begin
        // AH*BH plus everything above, result on the output
        step_signed_o  = req.short_signed;
        step_subword_o = 2'b11;
        ready_o        = 1'b1;
        // hold while the pipeline stalls
        if (ex_ready_i) begin
          state_d = IDLE_MULT;
        end
      end
      default: begin
        state_d = IDLE_MULT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE_MULT;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // bit 32 of the short sum, the sign of the 33 bit partial
      if (carry_save) begin
        carry_q <= ~carry_clear & sum_hi_i[0];
      end else if (ex_ready_i) begin
        carry_q <= 1'b0;
      end
    end
  end

  assign carry_o = carry_q;

endmodule

//--- hw/mac_int_unit.sv
////////////////////
// integer multiplier datapath
// 32 bit mac/msu and the 17x17 short path with round and shift
////////////////////

module mac_int_unit
  import mac_pkg::*;
(
  mac_req_if.int_sink         req,
  input  logic                mulh_active_i,
  input  logic [SHAMT_W-1:0]  step_imm_i,
  input  logic [1:0]          step_subword_i,
  input  logic [1:0]          step_signed_i,
  input  logic                step_shift_arith_i,
  input  logic                carry_i,
  output logic [1:0]          sum_hi_o,
  output logic [DATA_W-1:0]   int_result_o,
  output logic [DATA_W-1:0]   short_result_o
);

  ////////////////////
  // short path
  ////////////////////

  logic [SHAMT_W-1:0]    short_imm;
  logic [1:0]            short_subword;
  logic [1:0]            short_signed;
  logic                  short_shift_arith;
  logic [HALF_W:0]       short_op_a;
  logic [HALF_W:0]       short_op_b;
  logic [DATA_W:0]       short_op_c;
  logic [2*HALF_W+1:0]   short_mul;
  logic [DATA_W-1:0]     round_one;
  logic [DATA_W-1:0]     short_round;
  logic [DATA_W+1:0]     short_mac;
  logic                  mac_msb1;
  logic                  mac_msb0;
  logic [DATA_W+1:0]     short_shifted;

  // controls come from the sequencer while mulh runs
  assign short_imm         = mulh_active_i ? step_imm_i : req.imm;
  assign short_subword     = mulh_active_i ? step_subword_i : {2{req.short_subword}};
  assign short_signed      = mulh_active_i ? step_signed_i : req.short_signed;
  assign short_shift_arith = mulh_active_i ? step_shift_arith_i : req.short_signed[0];

  // half select, then one extra bit for signedness
  assign short_op_a[HALF_W-1:0] = short_subword[0] ? req.op_a[DATA_W-1:HALF_W]
                                                   : req.op_a[HALF_W-1:0];
  assign short_op_b[HALF_W-1:0] = short_subword[1] ? req.op_b[DATA_W-1:HALF_W]
                                                   : req.op_b[HALF_W-1:0];
  assign short_op_a[HALF_W] = short_signed[0] & short_op_a[HALF_W-1];
  assign short_op_b[HALF_W] = short_signed[1] & short_op_b[HALF_W-1];

  // mulh carries the sign of the previous partial above op_c
  assign short_op_c = mulh_active_i ? {carry_i, req.op_c} : {req.op_c[DATA_W-1], req.op_c};

  // half an lsb of the shifted result, zero for imm 0
  assign round_one   = {{(DATA_W-1){1'b0}}, 1'b1} << req.imm;
  assign short_round = (req.operator == MUL_IR) ? {1'b0, round_one[DATA_W-1:1]} : '0;

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_mac = {short_op_c[DATA_W], short_op_c} + short_mul + {2'b00, short_round};

  // top two bits only matter for mulh, else plain 32 bit sign
  assign mac_msb1 = mulh_active_i ? short_mac[DATA_W+1] : short_mac[DATA_W-1];
  assign mac_msb0 = mulh_active_i ? short_mac[DATA_W] : short_mac[DATA_W-1];

  assign short_shifted = $signed({short_shift_arith & mac_msb1, short_shift_arith & mac_msb0,
                                  short_mac[DATA_W-1:0]}) >>> short_imm;

  assign short_result_o = short_shifted[DATA_W-1:0];
  assign sum_hi_o       = short_mac[DATA_W+1:DATA_W];

  ////////////////////
  // 32 bit mac / msu
  ////////////////////

  logic                is_msu;
  logic [DATA_W-1:0]   int_op_a;
  logic [DATA_W-1:0]   int_op_b;

  // c - a*b = c + (~a)*b + b
  assign is_msu   = (req.operator == MUL_MSU32);
  assign int_op_a = req.op_a ^ {DATA_W{is_msu}};
  assign int_op_b = req.op_b & {DATA_W{is_msu}};

  assign int_result_o = req.op_c + int_op_b + int_op_a * req.op_b;

endmodule

//--- hw/mac_dot_unit.sv
////////////////////
// dot product datapath
// four byte and two half word products summed onto dot_op_c
////////////////////

module mac_dot_unit
  import mac_pkg::*;
(
  input  logic [1:0]         dot_signed_i,
  input  logic [DATA_W-1:0]  dot_op_a_i,
  input  logic [DATA_W-1:0]  dot_op_b_i,
  input  logic [DATA_W-1:0]  dot_op_c_i,
  output logic [DATA_W-1:0]  dot8_result_o,
  output logic [DATA_W-1:0]  dot16_result_o
);

  localparam int unsigned NB = DATA_W / BYTE_W;
  localparam int unsigned NH = DATA_W / HALF_W;

  logic [NB-1:0][BYTE_W:0]      byte_a;
  logic [NB-1:0][BYTE_W:0]      byte_b;
  logic [NB-1:0][2*BYTE_W+1:0]  byte_mul;
  logic [NH-1:0][HALF_W:0]      half_a;
  logic [NH-1:0][HALF_W:0]      half_b;
  logic [NH-1:0][2*HALF_W+1:0]  half_mul;

  // bit 1 signs A, bit 0 signs B
  for (genvar i = 0; i < NB; i++) begin : g_byte
    assign byte_a[i] = {dot_signed_i[1] & dot_op_a_i[BYTE_W*i+BYTE_W-1],
                        dot_op_a_i[BYTE_W*i +: BYTE_W]};
    assign byte_b[i] = {dot_signed_i[0] & dot_op_b_i[BYTE_W*i+BYTE_W-1],
                        dot_op_b_i[BYTE_W*i +: BYTE_W]};
    assign byte_mul[i] = $signed(byte_a[i]) * $signed(byte_b[i]);
  end

  for (genvar j = 0; j < NH; j++) begin : g_half
    assign half_a[j] = {dot_signed_i[1] & dot_op_a_i[HALF_W*j+HALF_W-1],
                        dot_op_a_i[HALF_W*j +: HALF_W]};
    assign half_b[j] = {dot_signed_i[0] & dot_op_b_i[HALF_W*j+HALF_W-1],
                        dot_op_b_i[HALF_W*j +: HALF_W]};
    assign half_mul[j] = $signed(half_a[j]) * $signed(half_b[j]);
  end

  // 18 bit signed products, extend before adding
  always_comb begin
    dot8_result_o = dot_op_c_i;
    for (int i = 0; i < NB; i++) begin
      dot8_result_o = dot8_result_o
                    + {{(DATA_W-2*BYTE_W-2){byte_mul[i][2*BYTE_W+1]}}, byte_mul[i]};
    end
  end

  // half word products wrap at 32 bits
  always_comb begin
    dot16_result_o = dot_op_c_i;
    for (int j = 0; j < NH; j++) begin
      dot16_result_o = dot16_result_o + half_mul[j][DATA_W-1:0];
    end
  end

endmodule

//--- hw/mac_result_sel.sv
////////////////////
// mac result select
// one word out of the datapath results by operator
////////////////////

module mac_result_sel
  import mac_pkg::*;
(
  input  mac_op_e            operator_i,
  input  logic [DATA_W-1:0]  int_result_i,
  input  logic [DATA_W-1:0]  short_result_i,
  input  logic [DATA_W-1:0]  dot8_result_i,
  input  logic [DATA_W-1:0]  dot16_result_i,
  output logic [DATA_W-1:0]  result_o
);

  always_comb begin
    result_o = '0;
    case (operator_i)
      // full word mac and msu
      MUL_MAC32, MUL_MSU32: begin
        result_o = int_result_i;
      end
      // short path, mulh included
      MUL_I, MUL_IR, MUL_H: begin
        result_o = short_result_i;
      end
      MUL_DOT8: begin
        result_o = dot8_result_i;
      end
      MUL_DOT16: begin
        result_o = dot16_result_i;
      end
      // unused encoding reads as zero
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

//--- hw/mac_unit.sv
////////////////////
// mac unit top level
// integer and dot multipliers for the execute stage
////////////////////

module mac_unit
  import mac_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  mac_op_e             operator_i,
  input  logic [DATA_W-1:0]   op_a_i,
  input  logic [DATA_W-1:0]   op_b_i,
  input  logic [DATA_W-1:0]   op_c_i,
  input  logic [SHAMT_W-1:0]  imm_i,
  input  logic                short_subword_i,
  input  logic [1:0]          short_signed_i,
  input  logic [1:0]          dot_signed_i,
  input  logic [DATA_W-1:0]   dot_op_a_i,
  input  logic [DATA_W-1:0]   dot_op_b_i,
  input  logic [DATA_W-1:0]   dot_op_c_i,
  input  logic                ex_ready_i,
  output logic [DATA_W-1:0]   result_o,
  output logic                multicycle_o,
  output logic                ready_o
);

  ////////////////////
  // request bundle
  ////////////////////

  mac_req_if req ();

  assign req.enable        = enable_i;
  assign req.operator      = operator_i;
  assign req.op_a          = op_a_i;
  assign req.op_b          = op_b_i;
  assign req.op_c          = op_c_i;
  assign req.imm           = imm_i;
  assign req.short_subword = short_subword_i;
  assign req.short_signed  = short_signed_i;
  assign req.dot_signed    = dot_signed_i;
  assign req.dot_op_a      = dot_op_a_i;
  assign req.dot_op_b      = dot_op_b_i;
  assign req.dot_op_c      = dot_op_c_i;

  ////////////////////
  // datapaths
  ////////////////////

  logic                mulh_active;
  logic [SHAMT_W-1:0]  step_imm;
  logic [1:0]          step_subword;
  logic [1:0]          step_signed;
  logic                step_shift_arith;
  logic                carry;
  logic [1:0]          sum_hi;
  logic [DATA_W-1:0]   int_result;
  logic [DATA_W-1:0]   short_result;
  logic [DATA_W-1:0]   dot8_result;
  logic [DATA_W-1:0]   dot16_result;

  mulh_ctrl i_mulh_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .req                (req),
    .ex_ready_i         (ex_ready_i),
    .sum_hi_i           (sum_hi),
    .mulh_active_o      (mulh_active),
    .step_imm_o         (step_imm),
    .step_subword_o     (step_subword),
    .step_signed_o      (step_signed),
    .step_shift_arith_o (step_shift_arith),
    .carry_o            (carry),
    .multicycle_o       (multicycle_o),
    .ready_o            (ready_o)
  );

  // short path feeds mulh partials back through sum_hi
  mac_int_unit i_mac_int_unit (
    .req                (req),
    .mulh_active_i      (mulh_active),
    .step_imm_i         (step_imm),
    .step_subword_i     (step_subword),
    .step_signed_i      (step_signed),
    .step_shift_arith_i (step_shift_arith),
    .carry_i            (carry),
    .sum_hi_o           (sum_hi),
    .int_result_o       (int_result),
    .short_result_o     (short_result)
  );

  mac_dot_unit i_mac_dot_unit (
    .dot_signed_i   (req.dot_signed),
    .dot_op_a_i     (req.dot_op_a),
    .dot_op_b_i     (req.dot_op_b),
    .dot_op_c_i     (req.dot_op_c),
    .dot8_result_o  (dot8_result),
    .dot16_result_o (dot16_result)
  );

  mac_result_sel i_mac_result_sel (
    .operator_i     (operator_i),
    .int_result_i   (int_result),
    .short_result_i (short_result),
    .dot8_result_i  (dot8_result),
    .dot16_result_i (dot16_result),
    .result_o       (result_o)
  );

endmodule

//--- verif/tb_clk_gen.sv
////////////////////
// testbench clock and reset
// free running clock, reset held low for a few cycles
////////////////////

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 4,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release just after an edge, away from any flop update
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- verif/mac_unit_tb.sv
////////////////////
// mac unit testbench
// table driven checks of every operator against reference models
////////////////////

module mac_unit_tb
  import mac_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned RESET_CYCLES = 8;
  // generous budget per table entry, mulh with hold needs about ten
  localparam int unsigned ENTRY_CYCLES = 10;

  // one table entry, exp is filled in by the reference models
  typedef struct packed {
    mac_op_e      op;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  c;
    logic [4:0]   imm;
    logic         sub;
    logic [1:0]   sgn;
    logic [2:0]   hold;
    logic [31:0]  exp;
  } vector_t;

  logic               clk;
  logic               rst_n;
  logic               enable_i;
  mac_op_e            operator_i;
  logic [DATA_W-1:0]  op_a_i;
  logic [DATA_W-1:0]  op_b_i;
  logic [DATA_W-1:0]  op_c_i;
  logic [SHAMT_W-1:0] imm_i;
  logic               short_subword_i;
  logic [1:0]         short_signed_i;
  logic [1:0]         dot_signed_i;
  logic [DATA_W-1:0]  dot_op_a_i;
  logic [DATA_W-1:0]  dot_op_b_i;
  logic [DATA_W-1:0]  dot_op_c_i;
  logic               ex_ready_i;
  logic [DATA_W-1:0]  result_o;
  logic               multicycle_o;
  logic               ready_o;

  vector_t     vectors[$];
  logic [31:0] lcg_state;
  logic        table_ready;
  int          errors;
  int          checks;

  tb_clk_gen #(
    .HALF_PERIOD  (CLK_PERIOD / 2),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mac_unit i_mac_unit (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable_i),
    .operator_i      (operator_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .imm_i           (imm_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .dot_signed_i    (dot_signed_i),
    .dot_op_a_i      (dot_op_a_i),
    .dot_op_b_i      (dot_op_b_i),
    .dot_op_c_i      (dot_op_c_i),
    .ex_ready_i      (ex_ready_i),
    .result_o        (result_o),
    .multicycle_o    (multicycle_o),
    .ready_o         (ready_o)
  );

  ////////////////////
  // reference models
  ////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // c plus or minus a*b, wraps at 32 bits
  function automatic logic [31:0] ref_mac32(logic msu, logic [31:0] a, logic [31:0] b,
                                            logic [31:0] c);
    return msu ? (c - a * b) : (c + a * b);
  endfunction

  // half word product plus c and rounding, then shift by imm
  function automatic logic [31:0] ref_short(logic round, logic [31:0] a, logic [31:0] b,
                                            logic [31:0] c, logic [4:0] imm, logic sub,
                                            logic [1:0] sgn);
    logic [15:0] ha;
    logic [15:0] hb;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] rnd;
    logic [63:0] sum;
    logic [31:0] low;
    ha  = sub ? a[31:16] : a[15:0];
    hb  = sub ? b[31:16] : b[15:0];
    ea  = sgn[0] ? {{48{ha[15]}}, ha} : {48'b0, ha};
    eb  = sgn[1] ? {{48{hb[15]}}, hb} : {48'b0, hb};
    // half an lsb of the result, nothing to round at imm 0
    rnd = (round && imm != 5'd0) ? (64'd1 << (imm - 5'd1)) : 64'd0;
    sum = ea * eb + {{32{c[31]}}, c} + rnd;
    low = sum[31:0];
    if (sgn[0]) begin
      return $signed(low) >>> imm;
    end
    return low >> imm;
  endfunction

  // upper word of the full 64 bit product
  function automatic logic [31:0] ref_mulh(logic [31:0] a, logic [31:0] b, logic [1:0] sgn);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = sgn[0] ? {{32{a[31]}}, a} : {32'b0, a};
    eb = sgn[1] ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ea * eb;
    return p[63:32];
  endfunction

  function automatic logic [31:0] ref_dot8(logic [31:0] a, logic [31:0] b, logic [31:0] c,
                                           logic [1:0] ds);
    logic [31:0] acc;
    logic [31:0] ea;
    logic [31:0] eb;
    acc = c;
    for (int i = 0; i < 4; i++) begin
      ea  = ds[1] ? {{24{a[8*i+7]}}, a[8*i +: 8]} : {24'b0, a[8*i +: 8]};
      eb  = ds[0] ? {{24{b[8*i+7]}}, b[8*i +: 8]} : {24'b0, b[8*i +: 8]};
      acc = acc + ea * eb;
    end
    return acc;
  endfunction

  function automatic logic [31:0] ref_dot16(logic [31:0] a, logic [31:0] b, logic [31:0] c,
                                            logic [1:0] ds);
    logic [31:0] acc;
    logic [31:0] ea;
    logic [31:0] eb;
    acc = c;
    for (int i = 0; i < 2; i++) begin
      ea  = ds[1] ? {{16{a[16*i+15]}}, a[16*i +: 16]} : {16'b0, a[16*i +: 16]};
      eb  = ds[0] ? {{16{b[16*i+15]}}, b[16*i +: 16]} : {16'b0, b[16*i +: 16]};
      acc = acc + ea * eb;
    end
    return acc;
  endfunction

  ////////////////////
  // stimulus table
  ////////////////////

  function automatic void push_vector(mac_op_e op, logic [31:0] a, logic [31:0] b,
                                      logic [31:0] c, logic [4:0] imm, logic sub,
                                      logic [1:0] sgn, logic [2:0] hold);
    vector_t v;
    v.op   = op;
    v.a    = a;
    v.b    = b;
    v.c    = c;
    v.imm  = imm;
    v.sub  = sub;
    v.sgn  = sgn;
    v.hold = hold;
    case (op)
      MUL_MAC32, MUL_MSU32: v.exp = ref_mac32(op == MUL_MSU32, a, b, c);
      MUL_I, MUL_IR:        v.exp = ref_short(op == MUL_IR, a, b, c, imm, sub, sgn);
      MUL_H:                v.exp = ref_mulh(a, b, sgn);
      MUL_DOT8:             v.exp = ref_dot8(a, b, c, sgn);
      default:              v.exp = ref_dot16(a, b, c, sgn);
    endcase
    vectors.push_back(v);
  endfunction

  task automatic build_table();
    mac_op_e     word_ops[2];
    mac_op_e     short_ops[2];
    mac_op_e     dot_ops[2];
    logic [4:0]  imms[5];
    logic [1:0]  hsgn[3];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    word_ops  = '{MUL_MAC32, MUL_MSU32};
    short_ops = '{MUL_I, MUL_IR};
    dot_ops   = '{MUL_DOT8, MUL_DOT16};
    imms      = '{5'd0, 5'd1, 5'd7, 5'd16, 5'd31};
    // both signed, signed by unsigned, unsigned
    hsgn      = '{2'b11, 2'b01, 2'b00};
    lcg_state = 32'h702f_d91a;
    // full word corners, then random
    push_vector(MUL_MAC32, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001,
                5'd0, 1'b0, 2'b00, 3'd0);
    push_vector(MUL_MSU32, 32'h8000_0000, 32'h0000_0003, 32'h7fff_ffff,
                5'd0, 1'b0, 2'b00, 3'd0);
    foreach (word_ops[k]) begin
      for (int i = 0; i < 6; i++) begin
        a = next_rand();
        b = next_rand();
        c = next_rand();
        push_vector(word_ops[k], a, b, c, 5'd0, 1'b0, 2'b00, 3'd0);
      end
    end
    // short path over subword, sign and shift amount
    foreach (short_ops[k]) begin
      for (int s = 0; s < 2; s++) begin
        for (int u = 0; u < 2; u++) begin
          foreach (imms[n]) begin
            a = next_rand();
            b = next_rand();
            c = next_rand();
            push_vector(short_ops[k], a, b, c, imms[n], 1'(u), (s != 0) ? 2'b11 : 2'b00,
                        3'd0);
          end
        end
      end
    end
    // mulh, one entry per sign holds FINISH for three cycles
    // another mulh issue follows each hold and sees the FSM back in idle
    foreach (hsgn[k]) begin
      push_vector(MUL_H, 32'h8000_0000, 32'h8000_0000, 32'h0, 5'd0, 1'b0, hsgn[k], 3'd0);
      push_vector(MUL_H, 32'hffff_ffff, 32'h7fff_ffff, 32'h0, 5'd0, 1'b0, hsgn[k], 3'd0);
      for (int i = 0; i < 3; i++) begin
        a = next_rand();
        b = next_rand();
        push_vector(MUL_H, a, b, 32'h0, 5'd0, 1'b0, hsgn[k], (i == 1) ? 3'd3 : 3'd0);
      end
    end
    foreach (dot_ops[k]) begin
      for (int s = 0; s < 4; s++) begin
        for (int i = 0; i < 2; i++) begin
          a = next_rand();
          b = next_rand();
          c = next_rand();
          push_vector(dot_ops[k], a, b, c, 5'd0, 1'b0, 2'(s), 3'd0);
        end
      end
    end
  endtask

  ////////////////////
  // drive and check
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // inputs change one unit after the rising edge
  task automatic next_drive_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic run_mulh(input vector_t v, input string tag);
    logic [31:0] part;
    int          steps;
    // ready falls already in the issue cycle
    check_value({tag, " ready_o at issue"}, 32'(ready_o), 32'd0);
    check_value({tag, " multicycle_o at issue"}, 32'(multicycle_o), 32'd0);
    next_drive_slot();
    enable_i = 1'b0;
    steps    = 0;
    @(negedge clk);
    // each partial goes back in on op_c, as the core does
    while (multicycle_o === 1'b1) begin
      check_value({tag, " ready_o in step"}, 32'(ready_o), 32'd0);
      part  = result_o;
      steps = steps + 1;
      next_drive_slot();
      op_c_i = part;
      @(negedge clk);
    end
    check_value({tag, " multicycle_o cycles"}, 32'(steps), 32'd3);
    check_value({tag, " ready_o in FINISH"}, 32'(ready_o), 32'd1);
    check_value({tag, " result_o"}, result_o, v.exp);
    // stalled pipeline keeps the FSM in FINISH
    for (int h = 0; h < int'(v.hold); h++) begin
      next_drive_slot();
      if (h == int'(v.hold) - 1) begin
        ex_ready_i = 1'b1;
      end
      @(negedge clk);
      check_value({tag, " ready_o in hold"}, 32'(ready_o), 32'd1);
      check_value({tag, " multicycle_o in hold"}, 32'(multicycle_o), 32'd0);
      check_value({tag, " result_o in hold"}, result_o, v.exp);
    end
    // the next entry's drive edge has ex_ready_i high and returns the FSM to idle
  endtask

  task automatic apply_vector(input int idx);
    vector_t v;
    mac_op_e op;
    string   tag;
    v   = vectors[idx];
    op  = v.op;
    tag = $sformatf("entry %0d %s", idx, op.name());
    next_drive_slot();
    enable_i        = 1'b1;
    operator_i      = v.op;
    op_a_i          = v.a;
    op_b_i          = v.b;
    // mulh starts from an empty accumulator
    op_c_i          = (v.op == MUL_H) ? 32'h0 : v.c;
    imm_i           = v.imm;
    short_subword_i = v.sub;
    short_signed_i  = v.sgn;
    dot_signed_i    = v.sgn;
    dot_op_a_i      = v.a;
    dot_op_b_i      = v.b;
    dot_op_c_i      = v.c;
    ex_ready_i      = !(v.op == MUL_H && v.hold != 3'd0);
    @(negedge clk);
    if (v.op == MUL_H) begin
      run_mulh(v, tag);
    end else begin
      check_value({tag, " result_o"}, result_o, v.exp);
      check_value({tag, " ready_o"}, 32'(ready_o), 32'd1);
      check_value({tag, " multicycle_o"}, 32'(multicycle_o), 32'd0);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    errors          = 0;
    checks          = 0;
    table_ready     = 1'b0;
    enable_i        = 1'b0;
    operator_i      = MUL_MAC32;
    op_a_i          = '0;
    op_b_i          = '0;
    op_c_i          = '0;
    imm_i           = '0;
    short_subword_i = 1'b0;
    short_signed_i  = 2'b00;
    dot_signed_i    = 2'b00;
    dot_op_a_i      = '0;
    dot_op_b_i      = '0;
    dot_op_c_i      = '0;
    ex_ready_i      = 1'b1;
    build_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("ready_o after reset", 32'(ready_o), 32'd1);
    check_value("multicycle_o after reset", 32'(multicycle_o), 32'd0);
    foreach (vectors[i]) begin
      apply_vector(i);
    end
    $display("mac_unit_tb: %0d entries, %0d checks, %0d errors",
             vectors.size(), checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // budget follows the table length
  initial begin
    int unsigned limit;
    wait (table_ready === 1'b1);
    limit = vectors.size() * ENTRY_CYCLES + RESET_CYCLES;
    repeat (limit) @(posedge clk);
    $display("watchdog: the run did not finish within %0d cycles and was stopped", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- mac_unit.f
hw/mac_pkg.sv
hw/mac_req_if.sv
hw/mulh_ctrl.sv
hw/mac_int_unit.sv
hw/mac_dot_unit.sv
hw/mac_result_sel.sv
hw/mac_unit.sv
verif/tb_clk_gen.sv
verif/mac_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the mac_unit testbench with verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f mac_unit.f \
  --top-module mac_unit_tb \
  --Mdir obj_dir -o Vmac_unit_tb

./obj_dir/Vmac_unit_tb | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "mac_unit: simulation passed"
else
  echo "mac_unit: simulation failed, see sim.log"
  exit 1
fi
